// File: logic/mem_op_pkg.sv
package mem_op_pkg;

    // low two bits give the width, bit 2 selects zero extension
    typedef enum logic [2:0] {
        LW   = 3'b000,
        LB   = 3'b001,
        LH   = 3'b010,
        LD   = 3'b011,
        LWU  = 3'b100,
        LBU  = 3'b101,
        LHU  = 3'b110,
        NONE = 3'b111
    } mem_op_t;

    // width classes in op[1:0]
    localparam logic [1:0] width_word  = 2'b00;
    localparam logic [1:0] width_byte  = 2'b01;
    localparam logic [1:0] width_half  = 2'b10;
    localparam logic [1:0] width_dword = 2'b11;

    localparam int zext_bit = 2;

    // request as issued by the core
    typedef struct packed {
        logic [63:0] addr;
        logic [63:0] wdata;
        logic        write;
        mem_op_t     op;
    } mem_req_t;

    // access after lane alignment, as seen by the cache
    typedef struct packed {
        logic [63:0] addr;
        logic        write;
        logic [63:0] data;
        logic [7:0]  mask;
    } cpu_access_t;

endpackage

// File: logic/cache_pkg.sv
package cache_pkg;

    // geometry
    localparam int line_bytes  = 16;
    localparam int index_bits  = 4;
    localparam int offset_bits = 4;
    localparam int tag_bits    = 64 - index_bits - offset_bits;   // 56
    localparam int num_lines   = 1 << index_bits;

    // one line, seen as doublewords or as bytes
    typedef union packed {
        logic [1:0][63:0]  dword;
        logic [15:0][7:0]  bytes;
    } cache_line_u;

    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [tag_bits-1:0] tag;
    } tag_entry_t;

    // line bus request, held with valid until ready
    typedef struct packed {
        logic [63:0] addr;     // line aligned
        logic        write;
        cache_line_u wdata;
    } line_req_t;

endpackage

// File: logic/store_align.sv
module store_align
    import mem_op_pkg::*;
(
    input  mem_req_t    req_i,
    output cpu_access_t acc_o
);

    logic [2:0]  offset;
    logic [63:0] narrow;       // store data trimmed to its width
    logic [7:0]  mask_base;
    logic [2:0]  align_bits;   // address bits that must be zero

    assign offset = req_i.addr[2:0];

    always_comb begin
        case (req_i.op[1:0])
            width_byte: begin
                narrow     = {56'b0, req_i.wdata[7:0]};
                mask_base  = 8'h01;
                align_bits = 3'b000;
            end
            width_half: begin
                narrow     = {48'b0, req_i.wdata[15:0]};
                mask_base  = 8'h03;
                align_bits = 3'b001;
            end
            width_word: begin
                narrow     = {32'b0, req_i.wdata[31:0]};
                mask_base  = 8'h0f;
                align_bits = 3'b011;
            end
            width_dword: begin
                narrow     = req_i.wdata;
                mask_base  = 8'hff;
                align_bits = 3'b111;
            end
        endcase
    end

    // loads pass through, the cache ignores the mask for them
    always_comb begin
        acc_o.addr  = req_i.addr;
        acc_o.write = req_i.write;
        acc_o.data  = narrow << {offset, 3'b000};
        acc_o.mask  = mask_base << offset;
    end

    // natural alignment only, a misaligned mask would lose bits off the top
    always_comb begin
        align_chk: assert final ($isunknown(req_i) || (offset & align_bits) == 3'b000)
            else $error("misaligned access at %h op %s", req_i.addr, req_i.op.name());
    end

endmodule

// File: logic/dcache.sv
module dcache
    import mem_op_pkg::*;
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  cpu_access_t acc_i,
    input  logic        acc_valid_i,
    output logic        idle_o,
    output logic        ready_o,
    output logic [63:0] rdata_o,

    output line_req_t   line_req_o,
    output logic        line_valid_o,
    input  logic        line_ready_i,
    input  cache_line_u line_rdata_i
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        RESPOND
    } state_t;

    state_t state_q, state_d;

    cache_line_u data_q [num_lines];
    tag_entry_t  tags_q [num_lines];

    cpu_access_t           acc_q;     // access being served
    logic [63:0]           rdata_q;
    logic [index_bits-1:0] acc_idx;
    logic [tag_bits-1:0]   acc_tag;
    logic                  dsel;      // which doubleword of the line
    tag_entry_t            entry;
    cache_line_u           line;
    cache_line_u           merged;
    logic                  hit;

    assign acc_idx = acc_q.addr[offset_bits +: index_bits];
    assign acc_tag = acc_q.addr[offset_bits + index_bits +: tag_bits];
    assign dsel    = acc_q.addr[offset_bits-1];

    assign entry = tags_q[acc_idx];
    assign line  = data_q[acc_idx];
    assign hit   = entry.valid && entry.tag == acc_tag;

    // store merge through the byte view
    always_comb begin
        merged = line;
        for (int b = 0; b < line_bytes; b++) begin
            if ((b >= 8) == dsel && acc_q.mask[b % 8]) begin
                merged.bytes[b] = acc_q.data[8*(b % 8) +: 8];
            end
        end
    end

    always_comb begin
        state_d          = state_q;
        line_valid_o     = 1'b0;
        line_req_o.addr  = {acc_tag, acc_idx, {offset_bits{1'b0}}};
        line_req_o.write = 1'b0;
        line_req_o.wdata = line;
        case (state_q)
            IDLE: begin
                if (acc_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_d = RESPOND;
                end else if (entry.valid && entry.dirty) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            WRITEBACK: begin
                line_valid_o     = 1'b1;
                line_req_o.addr  = {entry.tag, acc_idx, {offset_bits{1'b0}}};   // victim
                line_req_o.write = 1'b1;
                if (line_ready_i) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                line_valid_o = 1'b1;
                if (line_ready_i) begin
                    state_d = LOOKUP;   // retry, hits now
                end
            end
            RESPOND: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // control state and tag array
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            for (int i = 0; i < num_lines; i++) begin
                tags_q[i].valid <= 1'b0;
                tags_q[i].dirty <= 1'b0;
            end
        end else begin
            state_q <= state_d;
            if (state_q == LOOKUP && hit && acc_q.write) begin
                tags_q[acc_idx].dirty <= 1'b1;
            end
            if (state_q == REFILL && line_ready_i) begin
                tags_q[acc_idx] <= '{valid: 1'b1, dirty: 1'b0, tag: acc_tag};
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (state_q == IDLE && acc_valid_i) begin
            acc_q <= acc_i;
        end
        if (state_q == LOOKUP && hit) begin
            rdata_q <= line.dword[dsel];
            if (acc_q.write) begin
                data_q[acc_idx] <= merged;
            end
        end
        if (state_q == REFILL && line_ready_i) begin
            data_q[acc_idx] <= line_rdata_i;
        end
    end

    assign idle_o  = state_q == IDLE;
    assign ready_o = state_q == RESPOND;
    assign rdata_o = rdata_q;

    // a posted line request must not move before the memory answers
    line_hold: assert property (@(posedge clk) disable iff (rst)
        line_valid_o && !line_ready_i |=> line_valid_o && $stable(line_req_o));

endmodule

// File: logic/load_extend.sv
module load_extend
    import mem_op_pkg::*;
(
    input  logic [63:0] dword_i,
    input  logic [2:0]  offset_i,
    input  mem_op_t     op_i,
    output logic [63:0] rdata_o
);

    logic [63:0] shifted;   // addressed bytes moved to bit 0
    logic        zext;

    assign shifted = dword_i >> {offset_i, 3'b000};
    assign zext    = op_i[zext_bit];

    always_comb begin
        case (op_i[1:0])
            width_byte: begin
                rdata_o = {{56{shifted[7] & ~zext}}, shifted[7:0]};
            end
            width_half: begin
                rdata_o = {{48{shifted[15] & ~zext}}, shifted[15:0]};
            end
            width_word: begin
                rdata_o = {{32{shifted[31] & ~zext}}, shifted[31:0]};
            end
            width_dword: begin
                rdata_o = shifted;
            end
        endcase
        // 111 would decode as a zero-extended dword
        if (op_i == NONE) begin
            rdata_o = '0;
        end
    end

endmodule

// File: logic/mem_stage.sv
module mem_stage
    import mem_op_pkg::*;
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  mem_req_t    req_i,
    input  logic        mem_en_i,
    output logic        busy_o,
    output logic        done_o,
    output logic [63:0] rdata_o,

    output line_req_t   line_req_o,
    output logic        line_valid_o,
    input  logic        line_ready_i,
    input  cache_line_u line_rdata_i
);

    cpu_access_t acc;
    logic        acc_valid;
    logic        cache_idle;
    logic        cpu_ready;
    logic [63:0] cpu_rdata;
    logic        in_flight_q;
    logic        done_q;

    // result of the finished access, stable for the extractor
    logic [63:0] dword_q;
    logic [2:0]  offset_q;
    mem_op_t     op_q;

    store_align u_store_align (
        .req_i (req_i),
        .acc_o (acc)
    );

    // done_q keeps the held request from being issued a second time
    assign acc_valid = mem_en_i && !in_flight_q && !done_q && cache_idle;

    dcache u_dcache (
        .clk          (clk),
        .rst          (rst),
        .acc_i        (acc),
        .acc_valid_i  (acc_valid),
        .idle_o       (cache_idle),
        .ready_o      (cpu_ready),
        .rdata_o      (cpu_rdata),
        .line_req_o   (line_req_o),
        .line_valid_o (line_valid_o),
        .line_ready_i (line_ready_i),
        .line_rdata_i (line_rdata_i)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight_q <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            done_q <= cpu_ready;
            if (cpu_ready) begin
                in_flight_q <= 1'b0;
            end else if (acc_valid) begin
                in_flight_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_ready) begin
            dword_q  <= cpu_rdata;
            offset_q <= req_i.addr[2:0];   // req still held here
            op_q     <= req_i.op;
        end
    end

    load_extend u_load_extend (
        .dword_i  (dword_q),
        .offset_i (offset_q),
        .op_i     (op_q),
        .rdata_o  (rdata_o)
    );

    assign done_o = done_q;
    assign busy_o = mem_en_i && !done_q;

    // the core may only move the request once it has seen busy low
    req_hold: assert property (@(posedge clk) disable iff (rst)
        busy_o && $past(busy_o) |-> $stable(req_i));

endmodule

// File: sim/mem_model.sv
module mem_model
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  line_req_t   line_req_i,
    input  logic        line_valid_i,
    output logic        line_ready_o,
    output cache_line_u line_rdata_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int mem_bytes = 4096;
    localparam int max_delay = 5;

    logic [7:0]  mem [mem_bytes];   // read by the testbench as well
    integer      seed;
    logic        pending;
    int          delay;
    logic [11:0] base;

    assign base = {line_req_i.addr[11:4], 4'b0000};

    initial begin
        seed         = 94404;
        line_ready_o = 1'b0;
        line_rdata_o = '0;
        for (int a = 0; a < mem_bytes; a++) begin
            mem[a] = 8'(a * 7 + (a >> 8));   // every address bit shows up
        end
    end

    // ready pulses 0 to 5 cycles after the request is first seen
    always @(negedge clk) begin
        line_ready_o <= 1'b0;
        if (rst) begin
            pending <= 1'b0;
            delay   <= 0;
        end else if (line_valid_i && !line_ready_o) begin
            if (!pending) begin
                pending <= 1'b1;
                delay   <= $unsigned($random(seed)) % (max_delay + 1);
            end else if (delay != 0) begin
                delay <= delay - 1;
            end else begin
                pending      <= 1'b0;
                line_ready_o <= 1'b1;
                for (int b = 0; b < line_bytes; b++) begin
                    if (line_req_i.write) begin
                        mem[base + b] <= line_req_i.wdata.bytes[b];
                    end else begin
                        line_rdata_o.bytes[b] <= mem[base + b];
                    end
                end
            end
        end
    end

endmodule

// File: sim/tb_mem_stage.sv
module tb_mem_stage
    import mem_op_pkg::*;
    import cache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int mem_bytes      = 4096;
    localparam int access_timeout = 200;

    logic        clk;
    logic        rst;
    mem_req_t    req;
    logic        mem_en;
    logic        busy;
    logic        done;
    logic [63:0] rdata;
    line_req_t   line_req;
    logic        line_valid;
    logic        line_ready;
    cache_line_u line_rdata;

    logic [7:0] exp_mem [mem_bytes];   // what the core should see
    integer     seed;

    mem_stage DUT (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req),
        .mem_en_i     (mem_en),
        .busy_o       (busy),
        .done_o       (done),
        .rdata_o      (rdata),
        .line_req_o   (line_req),
        .line_valid_o (line_valid),
        .line_ready_i (line_ready),
        .line_rdata_i (line_rdata)
    );

    mem_model MEM (
        .clk          (clk),
        .rst          (rst),
        .line_req_i   (line_req),
        .line_valid_i (line_valid),
        .line_ready_o (line_ready),
        .line_rdata_o (line_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %b expected %b",
                $time, what, got, exp));
        end
    endtask

    task automatic check_rdata(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %h expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic check_line(input cache_line_u got, input cache_line_u exp,
                              input string what);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %h expected %h",
                $time, what, got, exp));
        end
    endtask

    function automatic int op_width_bytes(input mem_op_t op);
        case (op)
            LB, LBU: return 1;
            LH, LHU: return 2;
            LW, LWU: return 4;
            default: return 8;
        endcase
    endfunction

    // little endian gather with sign fill for LB, LH and LW
    function automatic logic [63:0] expected_load(input logic [63:0] addr, input mem_op_t op);
        int          n;
        logic [63:0] val;
        logic        sgn;
        n   = op_width_bytes(op);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val[8*i +: 8] = exp_mem[addr[11:0] + i];
        end
        sgn = (op == LB || op == LH || op == LW) && val[8*n-1];
        for (int i = 8 * n; i < 64; i++) begin
            val[i] = sgn;
        end
        if (op == NONE) begin
            val = '0;
        end
        return val;
    endfunction

    function automatic cache_line_u expected_line(input logic [63:0] addr);
        cache_line_u line;
        for (int i = 0; i < line_bytes; i++) begin
            line.bytes[i] = exp_mem[{addr[11:4], 4'b0000} + i];
        end
        return line;
    endfunction

    function automatic cache_line_u model_line(input logic [63:0] addr);
        cache_line_u line;
        for (int i = 0; i < line_bytes; i++) begin
            line.bytes[i] = MEM.mem[{addr[11:4], 4'b0000} + i];
        end
        return line;
    endfunction

    task automatic do_access(input logic [63:0] addr, input logic write, input mem_op_t op,
                             input logic [63:0] wdata, output logic [63:0] result);
        int cycles;
        @(negedge clk);
        req.addr  = addr;
        req.wdata = wdata;
        req.write = write;
        req.op    = op;
        mem_en    = 1'b1;
        cycles    = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > access_timeout) begin
                abort_run($sformatf("Timeout at %0t: done_o did not come within %0d cycles",
                    $time, access_timeout));
            end
            if (!done) begin
                check_flag(busy, 1'b1, "busy_o while access pending");
            end
        end while (!done);
        check_flag(busy, 1'b0, "busy_o in done cycle");
        result = rdata;
        mem_en = 1'b0;
        if (write) begin
            for (int i = 0; i < op_width_bytes(op); i++) begin
                exp_mem[addr[11:0] + i] = wdata[8*i +: 8];
            end
        end
    endtask

    task automatic idle_after_reset();
        repeat (20) begin
            @(negedge clk);
            check_flag(busy, 1'b0, "busy_o idle");
            check_flag(done, 1'b0, "done_o idle");
            check_flag(line_valid, 1'b0, "line_valid_o idle");
        end
    endtask

    task automatic widths_and_extension();
        logic [63:0] got;
        mem_op_t     op;
        do_access(64'h100, 1'b1, LD, 64'h8f7e_6d5c_c4b3_a291, got);
        for (int k = 0; k < 8; k++) begin
            op = mem_op_t'(k);
            for (int off = 0; off < 8; off += op_width_bytes(op)) begin
                do_access(64'h100 + off, 1'b0, op, '0, got);
                check_rdata(got, expected_load(64'h100 + off, op),
                    $sformatf("%s at offset %0d", op.name(), off));
            end
        end
    endtask

    task automatic byte_merge();
        mem_op_t     store_ops [3];
        logic [63:0] got;
        store_ops = '{LB, LH, LW};
        for (int w = 0; w < 3; w++) begin
            for (int off = 0; off < 8; off += op_width_bytes(store_ops[w])) begin
                do_access(64'h208 + off, 1'b1, store_ops[w], {$random(seed), $random(seed)}, got);
                do_access(64'h208, 1'b0, LD, '0, got);
                check_rdata(got, expected_load(64'h208, LD), "dword after narrow store");
                do_access(64'h200, 1'b0, LD, '0, got);
                check_rdata(got, expected_load(64'h200, LD), "other dword of the line");
            end
        end
    endtask

    task automatic dirty_eviction();
        logic [63:0] got;
        do_access(64'h340, 1'b1, LD, 64'h0123_4567_89ab_cdef, got);
        do_access(64'h348, 1'b1, LW, 64'h0000_0000_5555_aaaa, got);
        do_access(64'h440, 1'b1, LD, 64'hfedc_ba98_7654_3210, got);   // same index
        do_access(64'h348, 1'b0, LWU, '0, got);
        check_rdata(got, expected_load(64'h348, LWU), "reload of evicted line");
        check_line(model_line(64'h340), expected_line(64'h340), "written back line 0x340");
        check_line(model_line(64'h440), expected_line(64'h440), "written back line 0x440");
    endtask

    task automatic random_mix();
        int          tag_sel;
        int          idx;
        int          off;
        logic        write;
        mem_op_t     op;
        logic [63:0] addr;
        logic [63:0] got;
        for (int n = 0; n < 300; n++) begin
            tag_sel = $unsigned($random(seed)) % 4;
            idx     = $unsigned($random(seed)) % 3;
            off     = $unsigned($random(seed)) % 16;
            write   = $random(seed) & 1;
            if (write) begin
                op = mem_op_t'($unsigned($random(seed)) % 4);
            end else begin
                op = mem_op_t'($unsigned($random(seed)) % 8);
            end
            off     = off - off % op_width_bytes(op);
            addr    = 64'h800 + tag_sel * 256 + idx * 16 + off;
            do_access(addr, write, op, {$random(seed), $random(seed)}, got);
            if (!write) begin
                check_rdata(got, expected_load(addr, op),
                    $sformatf("random %s at %h", op.name(), addr));
            end
        end
    endtask

    initial begin
        seed   = 94404;
        rst    = 1'b1;
        mem_en = 1'b0;
        req    = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int a = 0; a < mem_bytes; a++) begin
            exp_mem[a] = MEM.mem[a];
        end
        idle_after_reset();
        widths_and_extension();
        byte_merge();
        dirty_eviction();
        random_mix();
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: sim.f
logic/mem_op_pkg.sv
logic/cache_pkg.sv
logic/store_align.sv
logic/dcache.sv
logic/load_extend.sv
logic/mem_stage.sv
sim/mem_model.sv
sim/tb_mem_stage.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - logic/mem_op_pkg.sv
  - logic/cache_pkg.sv
  - logic/store_align.sv
  - logic/dcache.sv
  - logic/load_extend.sv
  - logic/mem_stage.sv
  - target: simulation
    files:
      - sim/mem_model.sv
      - sim/tb_mem_stage.sv
